/* verilog/transducer_defines.svh */
`ifndef TRANSDUCER_DEFINES_SVH
`define TRANSDUCER_DEFINES_SVH

// address and data widths
`define TD_PADDR_WIDTH      40
`define TD_WORD_WIDTH       64
`define TD_RQTYPE_WIDTH     5
`define TD_SIZE_WIDTH       3
`define TD_RETTYPE_WIDTH    4

// instruction cache geometry with 32-byte lines
`define TD_IC_INDEX_BITS    7
`define TD_IC_OFFSET_BITS   5
`define TD_IC_TAG_BITS      (`TD_PADDR_WIDTH - `TD_IC_INDEX_BITS - `TD_IC_OFFSET_BITS)
`define TD_IC_BLOCK_BITS    (`TD_PADDR_WIDTH - `TD_IC_OFFSET_BITS)
`define TD_IC_LINE_WORDS    4

// data cache geometry with 16-byte lines
`define TD_DC_INDEX_BITS    8
`define TD_DC_OFFSET_BITS   4
`define TD_DC_TAG_BITS      (`TD_PADDR_WIDTH - `TD_DC_INDEX_BITS - `TD_DC_OFFSET_BITS)
`define TD_DC_BLOCK_BITS    (`TD_PADDR_WIDTH - `TD_DC_OFFSET_BITS)
`define TD_DC_LINE_WORDS    2

// invalidate address field carried with a response
`define TD_INVAL_MSB        15
`define TD_INVAL_LSB        4

// request types and size codes toward the L1.5
`define TD_RQ_LOAD          5'b00000
`define TD_RQ_IMISS         5'b10000
`define TD_RQ_STORE         5'b00001
`define TD_SZ_4B            3'b010
`define TD_SZ_16B           3'b111

// return types from the L1.5
`define TD_RET_LOAD         4'b0000
`define TD_RET_IFILL        4'b0001
`define TD_RET_EVICT        4'b0011
`define TD_RET_STACK        4'b0100
`define TD_RET_INT          4'b0111

`endif

/* verilog/transducer_pkg.sv */
`default_nettype none

`include "transducer_defines.svh"

package transducer_pkg;

    // plain vectors
    typedef logic [`TD_PADDR_WIDTH-1:0]   paddr_t;
    typedef logic [`TD_WORD_WIDTH-1:0]    word_t;
    typedef logic [`TD_RQTYPE_WIDTH-1:0]  rqtype_t;
    typedef logic [`TD_SIZE_WIDTH-1:0]    rqsize_t;
    typedef word_t [`TD_IC_LINE_WORDS-1:0] ic_line_t;
    typedef word_t [`TD_DC_LINE_WORDS-1:0] dc_line_t;
    typedef logic [`TD_IC_INDEX_BITS-1:0] ic_index_t;
    typedef logic [`TD_DC_INDEX_BITS-1:0] dc_index_t;
    typedef logic [`TD_IC_TAG_BITS-1:0]   ic_tag_t;
    typedef logic [`TD_DC_TAG_BITS-1:0]   dc_tag_t;

    // per-slot request state
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ARRIVE = 2'd1,
        ISSUE  = 2'd2
    } slot_state_e;

    typedef enum logic [`TD_RETTYPE_WIDTH-1:0] {
        RET_LOAD  = `TD_RET_LOAD,
        RET_IFILL = `TD_RET_IFILL,
        RET_EVICT = `TD_RET_EVICT,
        RET_STACK = `TD_RET_STACK,
        RET_INT   = `TD_RET_INT
    } ret_type_e;

    typedef struct packed {
        rqtype_t rqtype;
        rqsize_t size;
        paddr_t  addr;
        word_t   data;
    } l15_req_t;

    // one L1.5 return beat
    typedef struct packed {
        ret_type_e                            ret_type;
        paddr_t                               addr;
        word_t [3:0]                          data;
        logic                                 inval_dc;
        logic                                 inval_ic;
        logic [`TD_INVAL_MSB:`TD_INVAL_LSB]   inval_addr;
    } l15_resp_t;

    typedef struct packed {
        ic_tag_t   tag;
        ic_index_t index;
        ic_line_t  line;
    } ic_fill_t;

    typedef struct packed {
        dc_tag_t   tag;
        dc_index_t index;
        dc_line_t  line;
    } dc_fill_t;

endpackage

`default_nettype wire

/* verilog/req_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module req_slot (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    valid_i,
    input  wire transducer_pkg::l15_req_t req_i,
    input  wire logic                    grant_i,
    input  wire logic                    ack_i,
    output transducer_pkg::slot_state_e  state_o,
    output transducer_pkg::l15_req_t     req_o
);
    import transducer_pkg::*;

    slot_state_e state_q;
    slot_state_e state_d;
    l15_req_t    req_q;

    always_comb begin
        state_d = state_q;
        // the outstanding request retires on ack
        if (state_q == ISSUE && ack_i) begin
            state_d = IDLE;
        end
        // a new request overwrites whatever is pending
        if (valid_i) begin
            state_d = ARRIVE;
        end
        if (grant_i) begin
            state_d = ISSUE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request held for a later grant
    always_ff @(posedge clk) begin
        if (valid_i) begin
            req_q <= req_i;
        end
    end

    assign state_o = state_q;

    // fresh request is visible to the arbiter in its valid cycle
    assign req_o = valid_i ? req_i : req_q;

endmodule

`default_nettype wire

/* verilog/req_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire transducer_pkg::slot_state_e imiss_state_i,
    input  wire transducer_pkg::slot_state_e load_state_i,
    input  wire transducer_pkg::slot_state_e store_state_i,
    input  wire logic                        imiss_valid_i,
    input  wire logic                        load_valid_i,
    input  wire logic                        store_valid_i,
    input  wire transducer_pkg::l15_req_t    imiss_req_i,
    input  wire transducer_pkg::l15_req_t    load_req_i,
    input  wire transducer_pkg::l15_req_t    store_req_i,
    input  wire logic                        l15_ack_i,
    output logic [2:0]                       grant_o,
    output logic                             l15_val_o,
    output transducer_pkg::l15_req_t         l15_req_o
);
    import transducer_pkg::*;

    // bit 0 imiss, bit 1 load, bit 2 store
    logic [2:0] issuing;
    logic [2:0] arriving;
    logic       issue_ok;
    l15_req_t   grant_req;

    assign issuing = {
        store_state_i == ISSUE,
        load_state_i == ISSUE,
        imiss_state_i == ISSUE
    };

    assign arriving = {
        store_valid_i || store_state_i == ARRIVE,
        load_valid_i || load_state_i == ARRIVE,
        imiss_valid_i || imiss_state_i == ARRIVE
    };

    // bus is free or the current request retires this cycle
    assign issue_ok = (issuing == 3'b000) || l15_ack_i;

    // fixed priority of imiss over load over store
    always_comb begin
        grant_o = 3'b000;
        if (issue_ok) begin
            if (arriving[0]) begin
                grant_o = 3'b001;
            end else if (arriving[1]) begin
                grant_o = 3'b010;
            end else if (arriving[2]) begin
                grant_o = 3'b100;
            end
        end
    end

    always_comb begin
        case (grant_o)
            3'b010:  grant_req = load_req_i;
            3'b100:  grant_req = store_req_i;
            default: grant_req = imiss_req_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            l15_val_o <= 1'b0;
        end else if (grant_o != 3'b000) begin
            l15_val_o <= 1'b1;
        end else if (l15_ack_i) begin
            l15_val_o <= 1'b0;
        end
    end

    // request stays stable until the next grant
    always_ff @(posedge clk) begin
        if (grant_o != 3'b000) begin
            l15_req_o <= grant_req;
        end
    end

endmodule

`default_nettype wire

/* verilog/fill_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defines.svh"

module fill_formatter (
    input  wire transducer_pkg::l15_resp_t resp_i,
    output transducer_pkg::ic_fill_t       ic_fill_o,
    output transducer_pkg::dc_fill_t       dc_fill_o,
    output transducer_pkg::dc_index_t      inval_index_o
);
    import transducer_pkg::*;

    word_t [3:0] swapped;

    // L1.5 words are big endian and the core is little endian
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            swapped[i] = {<<8{resp_i.data[i]}};
        end
    end

    // instruction line takes all four words
    always_comb begin
        ic_fill_o.tag   = resp_i.addr[`TD_PADDR_WIDTH-1 -: `TD_IC_TAG_BITS];
        ic_fill_o.index = resp_i.addr[`TD_IC_OFFSET_BITS +: `TD_IC_INDEX_BITS];
        ic_fill_o.line  = swapped;
    end

    // data line takes words 1 and 0
    always_comb begin
        dc_fill_o.tag   = resp_i.addr[`TD_PADDR_WIDTH-1 -: `TD_DC_TAG_BITS];
        dc_fill_o.index = resp_i.addr[`TD_DC_OFFSET_BITS +: `TD_DC_INDEX_BITS];
        dc_fill_o.line  = swapped[1:0];
    end

    // same index field serves both caches
    assign inval_index_o = resp_i.inval_addr[`TD_INVAL_LSB +: `TD_DC_INDEX_BITS];

endmodule

`default_nettype wire

/* verilog/resp_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_decoder (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      resp_val_i,
    input  wire transducer_pkg::l15_resp_t resp_i,
    input  wire logic                      store_valid_i,
    output logic                           ic_fill_val_o,
    output logic                           dc_fill_val_o,
    output logic                           st_complete_o,
    output logic                           dc_inval_o,
    output logic                           ic_inval_o,
    output logic                           st_stall_o,
    output logic                           core_int_o
);
    import transducer_pkg::*;

    logic dc_inval_req;
    logic ic_inval_req;
    logic int_req;
    logic dc_inval_q;
    logic ic_inval_q;
    logic st_pending_q;

    always_comb begin
        ic_fill_val_o = 1'b0;
        dc_fill_val_o = 1'b0;
        st_complete_o = 1'b0;
        dc_inval_req  = 1'b0;
        ic_inval_req  = 1'b0;
        int_req       = 1'b0;
        if (resp_val_i) begin
            case (resp_i.ret_type)
                RET_LOAD:  dc_fill_val_o = 1'b1;
                RET_IFILL: ic_fill_val_o = 1'b1;
                RET_STACK: begin
                    // a store ack may carry an invalidation
                    st_complete_o = 1'b1;
                    dc_inval_req  = resp_i.inval_dc;
                    ic_inval_req  = resp_i.inval_ic;
                end
                RET_EVICT: begin
                    dc_inval_req = resp_i.inval_dc;
                    ic_inval_req = resp_i.inval_ic;
                end
                RET_INT:   int_req = 1'b1;
                default:   int_req = 1'b0;
            endcase
        end
    end

    // one-shot blocks back-to-back pulses per cache
    assign dc_inval_o = dc_inval_req && !dc_inval_q;
    assign ic_inval_o = ic_inval_req && !ic_inval_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dc_inval_q <= 1'b0;
            ic_inval_q <= 1'b0;
            core_int_o <= 1'b0;
        end else begin
            dc_inval_q <= dc_inval_o;
            ic_inval_q <= ic_inval_o;
            core_int_o <= int_req;
        end
    end

    // outstanding store bit where completion wins over a new store
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_pending_q <= 1'b0;
        end else if (st_complete_o) begin
            st_pending_q <= 1'b0;
        end else if (store_valid_i) begin
            st_pending_q <= 1'b1;
        end
    end

    assign st_stall_o = st_pending_q || store_valid_i;

endmodule

`default_nettype wire

/* verilog/l15_transducer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defines.svh"

module l15_transducer (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          ic_req_val_i,
    input  wire logic [`TD_IC_BLOCK_BITS-1:0]  ic_req_addr_i,
    input  wire logic                          dc_ld_val_i,
    input  wire logic [`TD_DC_BLOCK_BITS-1:0]  dc_ld_addr_i,
    input  wire logic                          dc_st_val_i,
    input  wire transducer_pkg::paddr_t        dc_st_addr_i,
    input  wire transducer_pkg::word_t         dc_st_data_i,
    input  wire transducer_pkg::rqsize_t       dc_st_size_i,
    input  wire logic                          l15_ack_i,
    output logic                               l15_val_o,
    output transducer_pkg::l15_req_t           l15_req_o,
    output logic                               l15_nc_o,
    input  wire logic                          l15_resp_val_i,
    input  wire transducer_pkg::l15_resp_t     l15_resp_i,
    output logic                               l15_req_ack_o,
    output logic                               ic_fill_val_o,
    output transducer_pkg::ic_fill_t           ic_fill_o,
    output logic                               ic_inval_val_o,
    output transducer_pkg::dc_index_t          ic_inval_index_o,
    output logic                               dc_fill_val_o,
    output transducer_pkg::dc_fill_t           dc_fill_o,
    output logic                               dc_st_complete_o,
    output logic                               dc_st_stall_o,
    output logic                               dc_inval_val_o,
    output transducer_pkg::dc_index_t          dc_inval_index_o,
    output logic                               core_int_o
);
    import transducer_pkg::*;

    l15_req_t    imiss_rec;
    l15_req_t    load_rec;
    l15_req_t    store_rec;
    l15_req_t    imiss_req;
    l15_req_t    load_req;
    l15_req_t    store_req;
    slot_state_e imiss_state;
    slot_state_e load_state;
    slot_state_e store_state;
    logic [2:0]  grant;
    word_t       st_data_swap;
    dc_index_t   inval_index;

    assign st_data_swap = {<<8{dc_st_data_i}};

    // block addresses back to full byte addresses
    assign imiss_rec = '{rqtype: `TD_RQ_IMISS, size: `TD_SZ_4B,
                         addr: {ic_req_addr_i, {`TD_IC_OFFSET_BITS{1'b0}}}, data: '0};
    assign load_rec  = '{rqtype: `TD_RQ_LOAD, size: `TD_SZ_16B,
                         addr: {dc_ld_addr_i, {`TD_DC_OFFSET_BITS{1'b0}}}, data: '0};
    assign store_rec = '{rqtype: `TD_RQ_STORE, size: dc_st_size_i,
                         addr: dc_st_addr_i, data: st_data_swap};

    req_slot imiss_slot_i (.clk(clk), .rst_n(rst_n), .valid_i(ic_req_val_i), .req_i(imiss_rec),
        .grant_i(grant[0]), .ack_i(l15_ack_i), .state_o(imiss_state), .req_o(imiss_req));
    req_slot load_slot_i (.clk(clk), .rst_n(rst_n), .valid_i(dc_ld_val_i), .req_i(load_rec),
        .grant_i(grant[1]), .ack_i(l15_ack_i), .state_o(load_state), .req_o(load_req));
    req_slot store_slot_i (.clk(clk), .rst_n(rst_n), .valid_i(dc_st_val_i), .req_i(store_rec),
        .grant_i(grant[2]), .ack_i(l15_ack_i), .state_o(store_state), .req_o(store_req));

    req_arbiter req_arbiter_i (
        .clk(clk), .rst_n(rst_n),
        .imiss_state_i(imiss_state), .load_state_i(load_state), .store_state_i(store_state),
        .imiss_valid_i(ic_req_val_i), .load_valid_i(dc_ld_val_i), .store_valid_i(dc_st_val_i),
        .imiss_req_i(imiss_req), .load_req_i(load_req), .store_req_i(store_req),
        .l15_ack_i(l15_ack_i), .grant_o(grant), .l15_val_o(l15_val_o), .l15_req_o(l15_req_o)
    );

    // top address bit selects the noncacheable space
    assign l15_nc_o = l15_req_o.addr[`TD_PADDR_WIDTH-1];

    fill_formatter fill_formatter_i (.resp_i(l15_resp_i), .ic_fill_o(ic_fill_o),
        .dc_fill_o(dc_fill_o), .inval_index_o(inval_index));

    resp_decoder resp_decoder_i (
        .clk(clk), .rst_n(rst_n), .resp_val_i(l15_resp_val_i), .resp_i(l15_resp_i),
        .store_valid_i(dc_st_val_i), .ic_fill_val_o(ic_fill_val_o),
        .dc_fill_val_o(dc_fill_val_o), .st_complete_o(dc_st_complete_o),
        .dc_inval_o(dc_inval_val_o), .ic_inval_o(ic_inval_val_o),
        .st_stall_o(dc_st_stall_o), .core_int_o(core_int_o)
    );

    assign l15_req_ack_o    = l15_resp_val_i;
    assign ic_inval_index_o = inval_index;
    assign dc_inval_index_o = inval_index;

endmodule

`default_nettype wire

/* verif/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// wrong-value and protocol error counts
int value_errors = 0;
int other_errors = 0;

task automatic check_req(input string name, input l15_req_t act, input l15_req_t exp);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp);
    end
endtask

task automatic check_ic_fill(input string name, input ic_fill_t act, input ic_fill_t exp);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp);
    end
endtask

task automatic check_dc_fill(input string name, input dc_fill_t act, input dc_fill_t exp);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp);
    end
endtask

task automatic check_index(input string name, input dc_index_t act, input dc_index_t exp);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp);
    end
endtask

task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
        value_errors++;
        $display("[FAIL] %0t %s: got %b, expected %b", $time, name, act, exp);
    end
endtask

task automatic protocol_error(input string what);
    other_errors++;
    $display("error at %0t: %s", $time, what);
endtask

`endif

/* verif/l15_transducer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defines.svh"

module l15_transducer_tb;
    import transducer_pkg::*;

    localparam int HOLD_MAX    = 6;
    localparam int WAIT_LIMIT  = 8;
    // five issued requests, plus reset and the response tests
    localparam int CYCLE_LIMIT = 5 * (WAIT_LIMIT + HOLD_MAX + 3) + 40;

    logic clk = 1'b0;
    logic rst_n;
    logic ic_req_val_i, dc_ld_val_i, dc_st_val_i, l15_ack_i, l15_resp_val_i;
    logic [`TD_IC_BLOCK_BITS-1:0] ic_req_addr_i;
    logic [`TD_DC_BLOCK_BITS-1:0] dc_ld_addr_i;
    paddr_t    dc_st_addr_i;
    word_t     dc_st_data_i;
    rqsize_t   dc_st_size_i;
    l15_resp_t l15_resp_i;
    logic l15_val_o, l15_nc_o, l15_req_ack_o, ic_fill_val_o, ic_inval_val_o;
    logic dc_fill_val_o, dc_st_complete_o, dc_st_stall_o, dc_inval_val_o, core_int_o;
    l15_req_t  l15_req_o;
    ic_fill_t  ic_fill_o;
    dc_fill_t  dc_fill_o;
    dc_index_t ic_inval_index_o, dc_inval_index_o;
    int        cycles = 0;

    `include "tb_checks.svh"

    l15_transducer l15_transducer_i (.*);

    always #10 clk = ~clk;

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, tests did not finish", cycles);
        $display("TEST FAIL");
        $finish;
    end

    function automatic word_t rand_word();
        return {$urandom(), $urandom()};
    endfunction

    // byte 0 trades places with byte 7, and so on
    function automatic word_t reverse_bytes(input word_t w);
        word_t r;
        for (int b = 0; b < 8; b++) begin
            r[8*b +: 8] = w[8*(7-b) +: 8];
        end
        return r;
    endfunction

    function automatic l15_req_t make_req(input rqtype_t t, input rqsize_t s,
                                          input paddr_t a, input word_t d);
        l15_req_t q;
        q.rqtype = t;
        q.size   = s;
        q.addr   = a;
        q.data   = d;
        return q;
    endfunction

    function automatic l15_resp_t make_resp(input ret_type_e t);
        l15_resp_t r;
        r.ret_type = t;
        r.addr     = paddr_t'(rand_word());
        for (int i = 0; i < 4; i++) begin
            r.data[i] = rand_word();
        end
        r.inval_dc   = 1'b0;
        r.inval_ic   = 1'b0;
        r.inval_addr = 12'($urandom());
        return r;
    endfunction

    function automatic ic_fill_t ic_expected(input l15_resp_t r);
        ic_fill_t f;
        f.tag   = ic_tag_t'(r.addr >> (`TD_IC_INDEX_BITS + `TD_IC_OFFSET_BITS));
        f.index = ic_index_t'(r.addr >> `TD_IC_OFFSET_BITS);
        for (int i = 0; i < 4; i++) begin
            f.line[i] = reverse_bytes(r.data[i]);
        end
        return f;
    endfunction

    function automatic dc_fill_t dc_expected(input l15_resp_t r);
        dc_fill_t f;
        f.tag   = dc_tag_t'(r.addr >> (`TD_DC_INDEX_BITS + `TD_DC_OFFSET_BITS));
        f.index = dc_index_t'(r.addr >> `TD_DC_OFFSET_BITS);
        for (int i = 0; i < 2; i++) begin
            f.line[i] = reverse_bytes(r.data[i]);
        end
        return f;
    endfunction

    task automatic drive_resp(input l15_resp_t r);
        @(posedge clk);
        l15_resp_val_i <= 1'b1;
        l15_resp_i     <= r;
    endtask

    task automatic end_resp();
        @(posedge clk);
        l15_resp_val_i <= 1'b0;
    endtask

    // waits for val without fixing the cycle
    task automatic expect_issue(input l15_req_t exp);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!l15_val_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!l15_val_o) begin
            protocol_error("no request reached the L1.5 in time");
        end else begin
            check_req("l15_req_o", l15_req_o, exp);
            check_bit("l15_nc_o", l15_nc_o, exp.addr[`TD_PADDR_WIDTH-1]);
        end
    endtask

    // request must stay put while the L1.5 holds off
    task automatic hold_and_ack(input l15_req_t exp);
        int hold;
        hold = $urandom_range(0, HOLD_MAX);
        repeat (hold) begin
            @(negedge clk);
            check_bit("l15_val_o", l15_val_o, 1'b1);
            check_req("l15_req_o", l15_req_o, exp);
        end
        @(posedge clk);
        l15_ack_i <= 1'b1;
        @(posedge clk);
        l15_ack_i <= 1'b0;
    endtask

    task automatic single_imiss();
        logic [`TD_IC_BLOCK_BITS-1:0] blk;
        l15_req_t exp;
        blk = (`TD_IC_BLOCK_BITS)'(rand_word());
        exp = make_req(`TD_RQ_IMISS, `TD_SZ_4B, paddr_t'(blk) << `TD_IC_OFFSET_BITS, '0);
        @(posedge clk);
        ic_req_val_i  <= 1'b1;
        ic_req_addr_i <= blk;
        @(negedge clk);
        check_bit("l15_val_o", l15_val_o, 1'b0);
        @(posedge clk);
        ic_req_val_i <= 1'b0;
        @(negedge clk);
        check_bit("l15_val_o", l15_val_o, 1'b1);
        check_req("l15_req_o", l15_req_o, exp);
        hold_and_ack(exp);
        @(negedge clk);
        check_bit("l15_val_o", l15_val_o, 1'b0);
    endtask

    task automatic three_way_priority();
        logic [`TD_IC_BLOCK_BITS-1:0] iblk;
        logic [`TD_DC_BLOCK_BITS-1:0] dblk;
        paddr_t   a;
        word_t    d;
        rqsize_t  s;
        l15_req_t exp [3];
        iblk = (`TD_IC_BLOCK_BITS)'(rand_word());
        dblk = (`TD_DC_BLOCK_BITS)'(rand_word());
        a = paddr_t'(rand_word());
        d = rand_word();
        s = rqsize_t'($urandom_range(0, 7));
        exp[0] = make_req(`TD_RQ_IMISS, `TD_SZ_4B, paddr_t'(iblk) << `TD_IC_OFFSET_BITS, '0);
        exp[1] = make_req(`TD_RQ_LOAD, `TD_SZ_16B, paddr_t'(dblk) << `TD_DC_OFFSET_BITS, '0);
        exp[2] = make_req(`TD_RQ_STORE, s, a, reverse_bytes(d));
        @(posedge clk);
        ic_req_val_i  <= 1'b1;
        ic_req_addr_i <= iblk;
        dc_ld_val_i   <= 1'b1;
        dc_ld_addr_i  <= dblk;
        dc_st_val_i   <= 1'b1;
        dc_st_addr_i  <= a;
        dc_st_data_i  <= d;
        dc_st_size_i  <= s;
        @(posedge clk);
        ic_req_val_i <= 1'b0;
        dc_ld_val_i  <= 1'b0;
        dc_st_val_i  <= 1'b0;
        for (int k = 0; k < 3; k++) begin
            expect_issue(exp[k]);
            hold_and_ack(exp[k]);
        end
        @(negedge clk);
        check_bit("l15_val_o", l15_val_o, 1'b0);
        // store ack so the stall drops before the next test
        drive_resp(make_resp(RET_STACK));
        end_resp();
    endtask

    task automatic store_path();
        paddr_t   a;
        word_t    d;
        rqsize_t  s;
        l15_req_t exp;
        a = paddr_t'(rand_word());
        d = rand_word();
        s = rqsize_t'($urandom_range(0, 7));
        exp = make_req(`TD_RQ_STORE, s, a, reverse_bytes(d));
        @(negedge clk);
        check_bit("dc_st_stall_o", dc_st_stall_o, 1'b0);
        @(posedge clk);
        dc_st_val_i  <= 1'b1;
        dc_st_addr_i <= a;
        dc_st_data_i <= d;
        dc_st_size_i <= s;
        @(negedge clk);
        check_bit("dc_st_stall_o", dc_st_stall_o, 1'b1);
        @(posedge clk);
        dc_st_val_i <= 1'b0;
        expect_issue(exp);
        hold_and_ack(exp);
        @(negedge clk);
        check_bit("dc_st_stall_o", dc_st_stall_o, 1'b1);
        drive_resp(make_resp(RET_STACK));
        @(negedge clk);
        check_bit("dc_st_complete_o", dc_st_complete_o, 1'b1);
        check_bit("dc_st_stall_o", dc_st_stall_o, 1'b1);
        end_resp();
        @(negedge clk);
        check_bit("dc_st_complete_o", dc_st_complete_o, 1'b0);
        check_bit("dc_st_stall_o", dc_st_stall_o, 1'b0);
    endtask

    task automatic fill_responses();
        l15_resp_t r;
        r = make_resp(RET_IFILL);
        drive_resp(r);
        @(negedge clk);
        check_bit("ic_fill_val_o", ic_fill_val_o, 1'b1);
        check_bit("dc_fill_val_o", dc_fill_val_o, 1'b0);
        check_bit("l15_req_ack_o", l15_req_ack_o, 1'b1);
        check_ic_fill("ic_fill_o", ic_fill_o, ic_expected(r));
        r = make_resp(RET_LOAD);
        drive_resp(r);
        @(negedge clk);
        check_bit("dc_fill_val_o", dc_fill_val_o, 1'b1);
        check_bit("ic_fill_val_o", ic_fill_val_o, 1'b0);
        check_bit("l15_req_ack_o", l15_req_ack_o, 1'b1);
        check_dc_fill("dc_fill_o", dc_fill_o, dc_expected(r));
        end_resp();
        @(negedge clk);
        check_bit("l15_req_ack_o", l15_req_ack_o, 1'b0);
        check_bit("dc_fill_val_o", dc_fill_val_o, 1'b0);
    endtask

    task automatic inval_and_interrupt();
        l15_resp_t r;
        dc_index_t idx;
        r = make_resp(RET_EVICT);
        r.inval_dc = 1'b1;
        r.inval_ic = 1'b1;
        // the field begins at address bit 4 so its low bits are the index
        idx = dc_index_t'(r.inval_addr);
        drive_resp(r);
        @(negedge clk);
        check_bit("dc_inval_val_o", dc_inval_val_o, 1'b1);
        check_bit("ic_inval_val_o", ic_inval_val_o, 1'b1);
        check_index("dc_inval_index_o", dc_inval_index_o, idx);
        check_index("ic_inval_index_o", ic_inval_index_o, idx);
        // back-to-back evict is swallowed
        drive_resp(r);
        @(negedge clk);
        check_bit("dc_inval_val_o", dc_inval_val_o, 1'b0);
        check_bit("ic_inval_val_o", ic_inval_val_o, 1'b0);
        drive_resp(make_resp(RET_INT));
        @(negedge clk);
        check_bit("core_int_o", core_int_o, 1'b0);
        end_resp();
        @(negedge clk);
        check_bit("core_int_o", core_int_o, 1'b1);
        @(negedge clk);
        check_bit("core_int_o", core_int_o, 1'b0);
        // both one-shots rearm after a gap
        drive_resp(r);
        @(negedge clk);
        check_bit("dc_inval_val_o", dc_inval_val_o, 1'b1);
        check_bit("ic_inval_val_o", ic_inval_val_o, 1'b1);
        end_resp();
    endtask

    initial begin
        void'($urandom(32'h1a3e2887));
        rst_n          <= 1'b0;
        ic_req_val_i   <= 1'b0;
        ic_req_addr_i  <= '0;
        dc_ld_val_i    <= 1'b0;
        dc_ld_addr_i   <= '0;
        dc_st_val_i    <= 1'b0;
        dc_st_addr_i   <= '0;
        dc_st_data_i   <= '0;
        dc_st_size_i   <= '0;
        l15_ack_i      <= 1'b0;
        l15_resp_val_i <= 1'b0;
        l15_resp_i     <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        single_imiss();
        three_way_priority();
        store_path();
        fill_responses();
        inval_and_interrupt();
        repeat (2) @(posedge clk);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
+incdir+verif
verilog/transducer_pkg.sv
verilog/req_slot.sv
verilog/req_arbiter.sv
verilog/fill_formatter.sv
verilog/resp_decoder.sv
verilog/l15_transducer.sv
verif/l15_transducer_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile the testbench with Verilator, run it, check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module l15_transducer_tb \
    -f project.f \
    -o l15_transducer_sim

./obj_dir/l15_transducer_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
